/* alu_execute.sv */
`timescale 1ns/10ps

module alu_execute (
    input  logic                            d_valid,
    input  isa_pkg::opcode_e                d_op,
    input  regs_pkg::part_e                 d_part,
    input  logic [isa_pkg::REG_IDX_W-1:0]   d_dst,
    input  logic [isa_pkg::REG_IDX_W-1:0]   d_src,
    input  logic [isa_pkg::IMM_W-1:0]       d_imm,
    input  logic [regs_pkg::GPR_W-1:0]      gpr_rdata_a,
    input  logic [regs_pkg::GPR_W-1:0]      gpr_rdata_b,
    input  logic [regs_pkg::MMX_W-1:0]      mmx_rdata_a,
    input  logic [regs_pkg::MMX_W-1:0]      mmx_rdata_b,
    output logic [isa_pkg::REG_IDX_W-1:0]   gpr_raddr_a,
    output logic [isa_pkg::REG_IDX_W-1:0]   gpr_raddr_b,
    output logic [isa_pkg::REG_IDX_W-1:0]   mmx_raddr_a,
    output logic [isa_pkg::REG_IDX_W-1:0]   mmx_raddr_b,
    output logic                            x_valid,
    output logic                            x_to_mmx,
    output regs_pkg::part_e                 x_part,
    output logic [isa_pkg::REG_IDX_W-1:0]   x_dst,
    output logic [regs_pkg::MMX_W-1:0]      x_value,
    output logic [regs_pkg::MMX_W-1:0]      x_merged
);

    localparam int PAD_W = regs_pkg::MMX_W - regs_pkg::GPR_W;

    logic [regs_pkg::GPR_W-1:0] dst_val, src_val, mask, res, merged;
    logic [regs_pkg::GPR_W-1:0] src_byte;
    logic [regs_pkg::MMX_W-1:0] mmx_res;

    // port a follows the destination, port b the source
    assign gpr_raddr_a = d_dst;
    assign gpr_raddr_b = d_src;
    assign mmx_raddr_a = d_dst;
    assign mmx_raddr_b = d_src;

    assign x_to_mmx = d_op inside {isa_pkg::OP_MOVD, isa_pkg::OP_MOVQ, isa_pkg::OP_PADDB,
                                   isa_pkg::OP_PADDW, isa_pkg::OP_PXOR};

    assign src_byte = d_imm[0] ? {24'b0, gpr_rdata_b[15:8]} : {24'b0, gpr_rdata_b[7:0]};

    always_comb begin
        case (d_part)
            regs_pkg::PART_L8: begin
                dst_val = {24'b0, gpr_rdata_a[7:0]};
                src_val = src_byte;
                mask    = 32'h0000_00ff;
            end
            regs_pkg::PART_H8: begin
                dst_val = {24'b0, gpr_rdata_a[15:8]};   // shifted down to bit 0
                src_val = src_byte;
                mask    = 32'h0000_00ff;
            end
            regs_pkg::PART_16: begin
                dst_val = {16'b0, gpr_rdata_a[15:0]};
                src_val = {16'b0, gpr_rdata_b[15:0]};
                mask    = 32'h0000_ffff;
            end
            default: begin
                dst_val = gpr_rdata_a;
                src_val = gpr_rdata_b;
                mask    = 32'hffff_ffff;
            end
        endcase

        case (d_op)
            isa_pkg::OP_MOVI: res = d_imm;
            isa_pkg::OP_ADD:  res = dst_val + src_val;
            isa_pkg::OP_SUB:  res = dst_val - src_val;
            isa_pkg::OP_AND:  res = dst_val & src_val;
            isa_pkg::OP_XOR:  res = dst_val ^ src_val;
            default:          res = src_val;
        endcase
        res = res & mask;   // wrap inside the part

        case (d_part)
            regs_pkg::PART_L8: merged = {gpr_rdata_a[31:8], res[7:0]};
            regs_pkg::PART_H8: merged = {gpr_rdata_a[31:16], res[7:0], gpr_rdata_a[7:0]};
            regs_pkg::PART_16: merged = {gpr_rdata_a[31:16], res[15:0]};
            default:           merged = res;
        endcase
    end

    always_comb begin
        mmx_res = mmx_rdata_b;
        case (d_op)
            isa_pkg::OP_MOVD: mmx_res = {{PAD_W{1'b0}}, gpr_rdata_b};
            isa_pkg::OP_PADDB: begin
                for (int i = 0; i < 8; i++) begin
                    mmx_res[i*8 +: 8] = mmx_rdata_a[i*8 +: 8] + mmx_rdata_b[i*8 +: 8];
                end
            end
            isa_pkg::OP_PADDW: begin
                for (int i = 0; i < 4; i++) begin
                    mmx_res[i*16 +: 16] = mmx_rdata_a[i*16 +: 16] + mmx_rdata_b[i*16 +: 16];
                end
            end
            isa_pkg::OP_PXOR: mmx_res = mmx_rdata_a ^ mmx_rdata_b;
            default:          mmx_res = mmx_rdata_b;    // MOVQ
        endcase
    end

    assign x_valid  = d_valid;
    assign x_part   = d_part;
    assign x_dst    = d_dst;
    assign x_value  = x_to_mmx ? mmx_res : {{PAD_W{1'b0}}, res};
    assign x_merged = x_to_mmx ? mmx_res : {{PAD_W{1'b0}}, merged};

endmodule

/* exec_core.sv */
`timescale 1ns/10ps

module exec_core (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            insn_valid,
    input  isa_pkg::opcode_e                opcode,
    input  isa_pkg::size_e                  size,
    input  logic [isa_pkg::REG_IDX_W-1:0]   dst,
    input  logic [isa_pkg::REG_IDX_W-1:0]   src,
    input  logic [isa_pkg::IMM_W-1:0]       imm,
    output logic                            result_valid,
    output logic [regs_pkg::MMX_W-1:0]      result
);

    // decode -> execute
    logic                           d_valid;
    isa_pkg::opcode_e               d_op;
    regs_pkg::part_e                d_part;
    logic [isa_pkg::REG_IDX_W-1:0]  d_dst, d_src;
    logic [isa_pkg::IMM_W-1:0]      d_imm;

    // register file read side
    logic [isa_pkg::REG_IDX_W-1:0]  gpr_raddr_a, gpr_raddr_b, mmx_raddr_a, mmx_raddr_b;
    logic [regs_pkg::GPR_W-1:0]     gpr_rdata_a, gpr_rdata_b;
    logic [regs_pkg::MMX_W-1:0]     mmx_rdata_a, mmx_rdata_b;

    // execute -> writeback
    logic                           x_valid, x_to_mmx;
    regs_pkg::part_e                x_part;
    logic [isa_pkg::REG_IDX_W-1:0]  x_dst;
    logic [regs_pkg::MMX_W-1:0]     x_value, x_merged;

    // write port
    logic                           gpr_we, mmx_we;
    regs_pkg::part_e                wr_part;
    logic [isa_pkg::REG_IDX_W-1:0]  waddr;
    logic [regs_pkg::MMX_W-1:0]     wdata;

    insn_decode u_decode (.*);

    alu_execute u_execute (.*);

    reg_file u_regs (.*);

    writeback u_writeback (.*);

endmodule

/* exec_core_assertions.sv */
`timescale 1ns/10ps

module exec_core_assertions (
    input logic                         clk,
    input logic                         reset,
    input logic                         insn_valid,
    input logic                         result_valid,
    input logic [regs_pkg::MMX_W-1:0]   result,
    input logic                         gpr_we,
    input logic                         mmx_we,
    input logic                         x_valid,
    input logic                         x_to_mmx
);

    int fail_count = 0;

    // fixed two-edge pipeline without stalls
    latency_a: assert property (@(posedge clk) disable iff (reset)
        insn_valid |-> ##2 result_valid)
        else begin
            fail_count++;
            $error("result_valid missing two edges after insn_valid");
        end

    no_orphan_a: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> $past(insn_valid, 2))
        else begin
            fail_count++;
            $error("result_valid without an instruction two edges earlier");
        end

    one_file_a: assert property (@(posedge clk) disable iff (reset)
        !(gpr_we && mmx_we))
        else begin
            fail_count++;
            $error("gpr_we and mmx_we high together");
        end

    gpr_upper_a: assert property (@(posedge clk) disable iff (reset)
        (x_valid && !x_to_mmx) |=> (result[regs_pkg::MMX_W-1:regs_pkg::GPR_W] == '0))
        else begin
            fail_count++;
            $error("upper half of result not zero for a general register");
        end

endmodule

bind exec_core exec_core_assertions u_assertions (.*);

/* exec_stim.txt */
# test(dec) opcode size dst src imm expected_result (hex)
1 1 2 0 0 00000000 0000000000000000
1 1 2 1 1 00000000 0000000000000000
1 1 2 2 2 00000000 0000000000000000
1 1 2 3 3 00000000 0000000000000000
1 1 2 4 4 00000000 0000000000000000
1 1 2 5 5 00000000 0000000000000000
1 1 2 6 6 00000000 0000000000000000
1 1 2 7 7 00000000 0000000000000000
1 7 2 2 6 00000000 0000000000000000
2 0 2 0 0 12345678 0000000012345678
2 0 1 0 0 ffffabcd 000000001234abcd
2 0 0 0 0 0000005a 000000001234ab5a
2 0 0 4 0 000001c7 000000001234c75a
2 0 0 7 0 00000099 0000000000009900
3 0 2 1 0 ffffff80 00000000ffffff80
3 2 2 1 0 00000000 000000001234c6da
3 3 1 1 3 00000000 0000000012342dda
3 4 0 1 4 00000000 0000000012342dc2
3 5 0 5 0 00000000 00000000123477c2
3 3 2 3 0 00000000 00000000edcbd1a6
3 4 1 3 1 00000000 00000000edcb5182
4 0 2 2 0 00000010 0000000000000010
4 2 2 2 2 00000000 0000000000000020
4 2 2 2 2 00000000 0000000000000040
4 1 2 4 2 00000000 0000000000000040
4 5 2 0 4 00000000 000000001234c71a
5 6 2 1 1 00000000 00000000123477c2
5 6 2 2 3 00000000 00000000edcb5182
5 8 2 1 2 00000000 00000000ffffc844
5 9 2 2 1 00000000 00000000edca19c6
5 a 2 1 2 00000000 000000001235d182
5 7 2 7 1 00000000 000000001235d182

/* insn_decode.sv */
`timescale 1ns/10ps

module insn_decode (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            insn_valid,
    input  isa_pkg::opcode_e                opcode,
    input  isa_pkg::size_e                  size,
    input  logic [isa_pkg::REG_IDX_W-1:0]   dst,
    input  logic [isa_pkg::REG_IDX_W-1:0]   src,
    input  logic [isa_pkg::IMM_W-1:0]       imm,
    output logic                            d_valid,
    output isa_pkg::opcode_e                d_op,
    output regs_pkg::part_e                 d_part,
    output logic [isa_pkg::REG_IDX_W-1:0]   d_dst,
    output logic [isa_pkg::REG_IDX_W-1:0]   d_src,
    output logic [isa_pkg::IMM_W-1:0]       d_imm
);

    logic                           is_mmx_op;
    regs_pkg::part_e                part_n;
    logic [isa_pkg::REG_IDX_W-1:0]  dst_n;
    logic [isa_pkg::REG_IDX_W-1:0]  src_n;
    logic [isa_pkg::IMM_W-1:0]      imm_n;

    assign is_mmx_op = opcode inside {isa_pkg::OP_MOVD, isa_pkg::OP_MOVQ, isa_pkg::OP_PADDB,
                                      isa_pkg::OP_PADDW, isa_pkg::OP_PXOR};

    always_comb begin
        part_n = regs_pkg::PART_32;     // MOVD reads the whole gpr
        dst_n  = dst;
        src_n  = src;
        imm_n  = imm;
        if (!is_mmx_op) begin
            case (size)
                isa_pkg::SZ_8: begin
                    // AH/CH/DH/BH live in bits 15:8 of registers 0..3
                    part_n = dst[2] ? regs_pkg::PART_H8 : regs_pkg::PART_L8;
                    dst_n  = {1'b0, dst[1:0]};
                    if (opcode != isa_pkg::OP_MOVI) begin
                        src_n    = {1'b0, src[1:0]};
                        imm_n    = '0;
                        imm_n[0] = src[2];  // unused imm carries the source byte select
                    end
                end
                isa_pkg::SZ_16: part_n = regs_pkg::PART_16;
                default:        part_n = regs_pkg::PART_32;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= insn_valid;
        end
        if (insn_valid) begin
            d_op   <= opcode;
            d_part <= part_n;
            d_dst  <= dst_n;
            d_src  <= src_n;
            d_imm  <= imm_n;
        end
    end

endmodule

/* isa_pkg.sv */
package isa_pkg;

    localparam int REG_IDX_W = 3;   // eight architectural registers per file
    localparam int IMM_W     = 32;

    // scalar ops first, then the MMX group
    typedef enum logic [3:0] {
        OP_MOVI  = 4'd0,
        OP_MOV   = 4'd1,
        OP_ADD   = 4'd2,
        OP_SUB   = 4'd3,
        OP_AND   = 4'd4,
        OP_XOR   = 4'd5,
        OP_MOVD  = 4'd6,    // gpr to mmx with zero extension
        OP_MOVQ  = 4'd7,
        OP_PADDB = 4'd8,
        OP_PADDW = 4'd9,
        OP_PXOR  = 4'd10
    } opcode_e;

    typedef enum logic [1:0] {
        SZ_8  = 2'd0,
        SZ_16 = 2'd1,
        SZ_32 = 2'd2
    } size_e;

endpackage

/* reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            gpr_we,
    input  logic                            mmx_we,
    input  regs_pkg::part_e                 wr_part,
    input  logic [isa_pkg::REG_IDX_W-1:0]   waddr,
    input  logic [regs_pkg::MMX_W-1:0]      wdata,
    input  logic [isa_pkg::REG_IDX_W-1:0]   gpr_raddr_a,
    input  logic [isa_pkg::REG_IDX_W-1:0]   gpr_raddr_b,
    input  logic [isa_pkg::REG_IDX_W-1:0]   mmx_raddr_a,
    input  logic [isa_pkg::REG_IDX_W-1:0]   mmx_raddr_b,
    output logic [regs_pkg::GPR_W-1:0]      gpr_rdata_a,
    output logic [regs_pkg::GPR_W-1:0]      gpr_rdata_b,
    output logic [regs_pkg::MMX_W-1:0]      mmx_rdata_a,
    output logic [regs_pkg::MMX_W-1:0]      mmx_rdata_b
);

    localparam int GPR_BYTES = regs_pkg::GPR_W / 8;

    logic [regs_pkg::GPR_W-1:0] gpr [regs_pkg::NUM_REGS];
    logic [regs_pkg::MMX_W-1:0] mmx [regs_pkg::NUM_REGS];
    logic [GPR_BYTES-1:0]       byte_en;

    // byte lanes touched by a sized write
    always_comb begin
        case (wr_part)
            regs_pkg::PART_L8: byte_en = 4'b0001;
            regs_pkg::PART_H8: byte_en = 4'b0010;
            regs_pkg::PART_16: byte_en = 4'b0011;
            default:           byte_en = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regs_pkg::NUM_REGS; i++) begin
                gpr[i] <= '0;
                mmx[i] <= '0;
            end
        end else begin
            if (gpr_we) begin
                for (int b = 0; b < GPR_BYTES; b++) begin
                    if (byte_en[b]) begin
                        gpr[waddr][b*8 +: 8] <= wdata[b*8 +: 8];  // other lanes hold
                    end
                end
            end
            if (mmx_we) begin
                mmx[waddr] <= wdata;
            end
        end
    end

    // read ports see the array directly, a write lands on the edge before the next read
    assign gpr_rdata_a = gpr[gpr_raddr_a];
    assign gpr_rdata_b = gpr[gpr_raddr_b];
    assign mmx_rdata_a = mmx[mmx_raddr_a];
    assign mmx_rdata_b = mmx[mmx_raddr_b];

endmodule

/* regs_pkg.sv */
package regs_pkg;

    localparam int GPR_W    = 32;
    localparam int MMX_W    = 64;
    localparam int NUM_REGS = 8;

    // which bits of a general register a write touches
    typedef enum logic [1:0] {
        PART_L8 = 2'd0,     // bits 7:0
        PART_H8 = 2'd1,     // bits 15:8
        PART_16 = 2'd2,     // bits 15:0
        PART_32 = 2'd3      // bits 31:0
    } part_e;

endpackage

/* sources.f */
isa_pkg.sv
regs_pkg.sv
insn_decode.sv
reg_file.sv
alu_execute.sv
writeback.sv
exec_core.sv
exec_core_assertions.sv
tb_clock.sv
tb_exec_core.sv

/* tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #4 clk = ~clk;   // 8 ns period

endmodule

/* tb_exec_core.sv */
`timescale 1ns/10ps

module tb_exec_core;

    logic                           clk;
    logic                           reset;
    logic                           insn_valid;
    isa_pkg::opcode_e               opcode;
    isa_pkg::size_e                 size;
    logic [isa_pkg::REG_IDX_W-1:0]  dst;
    logic [isa_pkg::REG_IDX_W-1:0]  src;
    logic [isa_pkg::IMM_W-1:0]      imm;
    logic                           result_valid;
    logic [regs_pkg::MMX_W-1:0]     result;

    // one entry per stimulus line
    int             test_a[64];
    logic [3:0]     op_a[64];
    logic [1:0]     size_a[64];
    logic [2:0]     dst_a[64], src_a[64];
    logic [31:0]    imm_a[64];
    logic [63:0]    exp_a[64];

    logic [63:0]    pending_q[$];
    int             issue_q[$];     // edge on which each strobe was driven
    int             edge_cnt = 0;
    int             checks = 0;
    int             errors = 0;
    int             assert_seen = 0;

    tb_clock clk_gen (.clk(clk));

    exec_core dut0 (.*);

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    // failures of the bound assertions since the last call
    task automatic collect_assertion_failures();
        errors      += dut0.u_assertions.fail_count - assert_seen;
        assert_seen  = dut0.u_assertions.fail_count;
    endtask

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    // sampled mid-cycle away from the edge that sets result
    always @(negedge clk) begin
        if (result_valid) begin
            if (pending_q.size() == 0) begin
                $display("result_valid was high with no instruction outstanding");
                errors++;
            end else begin
                check_value("result", result, pending_q.pop_front());
                check_value("latency", edge_cnt - issue_q.pop_front(), 2);
            end
        end
    end

    initial begin
        int     fd, n, i, t, waited, first_err, tests;
        string  line;
        bit     timed_out;

        reset      = 1'b1;
        insn_valid = 1'b0;
        opcode     = isa_pkg::OP_MOVI;
        size       = isa_pkg::SZ_32;
        dst        = '0;
        src        = '0;
        imm        = '0;
        tests      = 0;
        timed_out  = 1'b0;

        n  = 0;
        fd = $fopen("exec_stim.txt", "r");
        while (fd != 0 && n < 64 && $fgets(line, fd)) begin
            if ($sscanf(line, "%d %h %h %h %h %h %h", test_a[n], op_a[n], size_a[n],
                        dst_a[n], src_a[n], imm_a[n], exp_a[n]) == 7) begin
                n++;    // comment lines do not scan
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (n == 0) begin
            $display("no stimulus lines could be read from exec_stim.txt");
            errors++;
        end

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        i = 0;
        while (i < n && !timed_out) begin
            t         = test_a[i];
            first_err = errors;
            while (i < n && test_a[i] == t) begin
                @(posedge clk);
                insn_valid <= 1'b1;
                opcode     <= isa_pkg::opcode_e'(op_a[i]);
                size       <= isa_pkg::size_e'(size_a[i]);
                dst        <= dst_a[i];
                src        <= src_a[i];
                imm        <= imm_a[i];
                pending_q.push_back(exp_a[i]);
                issue_q.push_back(edge_cnt + 1);    // counter still shows the previous edge
                i++;
            end
            @(posedge clk);
            insn_valid <= 1'b0;
            waited = 0;
            while (pending_q.size() != 0 && waited < 20) begin
                @(posedge clk);
                waited++;
            end
            if (pending_q.size() != 0) begin
                $display("test %0d: no result arrived within 20 cycles", t);
                errors++;
                timed_out = 1'b1;
            end
            collect_assertion_failures();
            $display("test %0d %s", t, (errors == first_err) ? "passed" : "failed");
            tests++;
        end

        collect_assertion_failures();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* writeback.sv */
`timescale 1ns/10ps

module writeback (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            x_valid,
    input  logic                            x_to_mmx,
    input  regs_pkg::part_e                 x_part,
    input  logic [isa_pkg::REG_IDX_W-1:0]   x_dst,
    input  logic [regs_pkg::MMX_W-1:0]      x_value,
    input  logic [regs_pkg::MMX_W-1:0]      x_merged,
    output logic                            gpr_we,
    output logic                            mmx_we,
    output regs_pkg::part_e                 wr_part,
    output logic [isa_pkg::REG_IDX_W-1:0]   waddr,
    output logic [regs_pkg::MMX_W-1:0]      wdata,
    output logic                            result_valid,
    output logic [regs_pkg::MMX_W-1:0]      result
);

    // write port is driven straight from execute, the array captures it on the next edge
    assign gpr_we  = x_valid && !x_to_mmx;
    assign mmx_we  = x_valid && x_to_mmx;
    assign wr_part = x_part;
    assign waddr   = x_dst;

    always_comb begin
        wdata = x_value;
        if (!x_to_mmx && x_part == regs_pkg::PART_H8) begin
            wdata = x_value << 8;   // high byte sits in bits 15:8
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= x_valid;
        end
        if (x_valid) begin
            result <= x_merged;     // same value the register holds after this edge
        end
    end

endmodule
